// ==== mem_pkg.sv ====
package mem_pkg;

    ////////////////////////////////////////////////////////////
    // Address map
    ////////////////////////////////////////////////////////////
    localparam logic [31:0] RAM_BASE             = 32'h8000_0000;
    localparam int          MEM_WORDS            = 1024;
    localparam int          MEM_IDX_W            = $clog2(MEM_WORDS);
    localparam logic [31:0] RAM_BYTES            = 32'(MEM_WORDS * 4);

    localparam logic [31:0] UART_TX_ADDR         = 32'h1000_0000;
    localparam logic [31:0] UART_STATUS_ADDR     = 32'h1000_0005; // bit0 not full and bit1 idle

    localparam logic [31:0] CLINT_MSIP_ADDR      = 32'h0200_0000;
    localparam logic [31:0] CLINT_MTIMECMP_ADDR  = 32'h0200_4000;
    localparam logic [31:0] CLINT_MTIMECMPH_ADDR = 32'h0200_4004;
    localparam logic [31:0] CLINT_MTIME_ADDR     = 32'h0200_BFF8;
    localparam logic [31:0] CLINT_MTIMEH_ADDR    = 32'h0200_BFFC;

    // UART sizing
    localparam int UART_FIFO_DEPTH   = 8;
    localparam int UART_PTR_W        = $clog2(UART_FIFO_DEPTH);
    localparam int UART_CNT_W        = $clog2(UART_FIFO_DEPTH + 1);
    localparam int UART_CLKS_PER_BIT = 8;
    localparam int UART_TMR_W        = $clog2(UART_CLKS_PER_BIT);

    localparam logic [31:0] INST_NOP = 32'h0000_0013; // addi x0, x0, 0

    // Pipeline hazard code
    typedef enum logic [3:0] {
        HZ_NONE        = 4'd0,
        HZ_STALL_EARLY = 4'd1,
        HZ_STALL_MMU   = 4'd2,
        HZ_FLUSH_EARLY = 4'd3,
        HZ_FLUSH_ALL   = 4'd4
    } hazard_t;

    // Access width in funct3 encoding
    typedef enum logic [2:0] {
        MW_B  = 3'd0,
        MW_H  = 3'd1,
        MW_W  = 3'd2,
        MW_BU = 3'd4,
        MW_HU = 3'd5
    } mem_width_t;

endpackage

// ==== unified_ram.sv ====
`timescale 1ns/1ns

module unified_ram (
    input  logic                           clk,
    // Fetch port
    input  logic [31:0]                    fetch_addr_i,
    output logic [31:0]                    fetch_word_o,
    // Data port
    input  logic                           we_i,
    input  logic [mem_pkg::MEM_IDX_W-1:0]  word_idx_i,
    input  logic [1:0]                     offset_i,
    input  mem_pkg::mem_width_t            width_i,
    input  logic [31:0]                    wdata_i,
    output logic [31:0]                    rdata_o
);
    import mem_pkg::*;

    logic [31:0] mem [0:MEM_WORDS-1];

    logic [31:0]          fetch_off;
    logic [MEM_IDX_W-1:0] fetch_idx;
    logic [31:0]          rd_word;
    logic [7:0]           byte_lane;
    logic [15:0]          half_lane;
    logic                 half_ok;
    logic                 word_ok;

    ////////////////////////////////////////////////////////////
    // Fetch port
    ////////////////////////////////////////////////////////////
    assign fetch_off    = fetch_addr_i - RAM_BASE;
    assign fetch_idx    = fetch_off[MEM_IDX_W+1:2];
    assign fetch_word_o = mem[fetch_idx];

    assign half_ok = ~offset_i[0];       // offsets 0 and 2 only
    assign word_ok = (offset_i == 2'd0);

    ////////////////////////////////////////////////////////////
    // Stores
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (we_i) begin
            case (width_i)
                MW_B: begin
                    mem[word_idx_i][8*offset_i +: 8] <= wdata_i[7:0];
                end
                MW_H: begin
                    if (half_ok) begin
                        mem[word_idx_i][16*offset_i[1] +: 16] <= wdata_i[15:0];
                    end
                end
                MW_W: begin
                    if (word_ok) begin
                        mem[word_idx_i] <= wdata_i;
                    end
                end
                default: ; // Unsigned widths are load only
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Loads
    ////////////////////////////////////////////////////////////
    assign rd_word   = mem[word_idx_i];
    assign byte_lane = rd_word[8*offset_i +: 8];
    assign half_lane = offset_i[1] ? rd_word[31:16] : rd_word[15:0];

    always_comb begin
        rdata_o = 32'h0;
        case (width_i)
            MW_B:  rdata_o = {{24{byte_lane[7]}}, byte_lane};
            MW_BU: rdata_o = {24'h0, byte_lane};
            MW_H: begin
                if (half_ok) begin
                    rdata_o = {{16{half_lane[15]}}, half_lane};
                end
            end
            MW_HU: begin
                if (half_ok) begin
                    rdata_o = {16'h0, half_lane};
                end
            end
            MW_W: begin
                if (word_ok) begin
                    rdata_o = rd_word;
                end
            end
            default: rdata_o = 32'h0;
        endcase
    end

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage (
    input  logic             clk,
    input  logic             rst,
    input  mem_pkg::hazard_t hazard_i,
    input  logic [31:0]      pc_i,
    input  logic [31:0]      fetch_word_i,
    output logic [31:0]      inst_o,
    output logic [31:0]      id_pc_o
);
    import mem_pkg::*;

    logic flush;
    logic stall;
    logic [31:0] inst_q;
    logic [31:0] id_pc_q;

    assign flush = (hazard_i == HZ_FLUSH_EARLY) || (hazard_i == HZ_FLUSH_ALL);
    assign stall = (hazard_i == HZ_STALL_EARLY) || (hazard_i == HZ_STALL_MMU);

    // IF/ID pipeline register
    always_ff @(posedge clk) begin
        if (rst) begin
            inst_q  <= INST_NOP;
            id_pc_q <= 32'h0;
        end else if (flush) begin
            inst_q <= INST_NOP; // Bubble keeps old PC
        end else if (!stall) begin
            inst_q  <= fetch_word_i;
            id_pc_q <= pc_i;
        end
    end

    assign inst_o  = inst_q;
    assign id_pc_o = id_pc_q;

endmodule

// ==== clint_timer.sv ====
`timescale 1ns/1ns

module clint_timer (
    input  logic        clk,
    input  logic        rst,
    input  logic        we_i,
    input  logic [31:0] addr_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] rdata_o,
    output logic        msip_o,
    output logic        mtip_o
);
    import mem_pkg::*;

    logic [31:0] mtime_lo;
    logic [31:0] mtime_hi;
    logic [31:0] cmp_lo;
    logic [31:0] cmp_hi;
    logic        msip_q;

    // Free running mtime with carry into high word
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime_lo <= 32'h0;
            mtime_hi <= 32'h0;
        end else begin
            mtime_lo <= mtime_lo + 32'd1;
            if (we_i && addr_i == CLINT_MTIMEH_ADDR) begin
                mtime_hi <= wdata_i;
            end else if (mtime_lo == 32'hFFFF_FFFF) begin
                mtime_hi <= mtime_hi + 32'd1;
            end
        end
    end

    // Software writable registers
    always_ff @(posedge clk) begin
        if (rst) begin
            cmp_lo <= 32'hFFFF_FFFF;
            cmp_hi <= 32'hFFFF_FFFF;
            msip_q <= 1'b0;
        end else if (we_i) begin
            case (addr_i)
                CLINT_MSIP_ADDR:      msip_q <= wdata_i[0];
                CLINT_MTIMECMP_ADDR:  cmp_lo <= wdata_i;
                CLINT_MTIMECMPH_ADDR: cmp_hi <= wdata_i;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (addr_i)
            CLINT_MSIP_ADDR:      rdata_o = {31'h0, msip_q};
            CLINT_MTIMECMP_ADDR:  rdata_o = cmp_lo;
            CLINT_MTIMECMPH_ADDR: rdata_o = cmp_hi;
            CLINT_MTIME_ADDR:     rdata_o = mtime_lo;
            CLINT_MTIMEH_ADDR:    rdata_o = mtime_hi;
            default:              rdata_o = 32'h0;
        endcase
    end

    assign msip_o = msip_q;
    assign mtip_o = ({mtime_hi, mtime_lo} >= {cmp_hi, cmp_lo});

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ns

module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic       push_i,
    input  logic [7:0] byte_i,
    output logic       not_full_o,
    output logic       idle_o,
    output logic       tx_o
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    logic [7:0]            fifo [0:UART_FIFO_DEPTH-1];
    logic [UART_PTR_W-1:0] wr_ptr;
    logic [UART_PTR_W-1:0] rd_ptr;
    logic [UART_CNT_W-1:0] count;
    logic                  full;
    logic                  do_push;
    logic                  do_pop;

    tx_state_t             state;
    logic [UART_TMR_W-1:0] bit_tmr;
    logic                  bit_end;
    logic [2:0]            bit_idx;
    logic [7:0]            shift_q;
    logic                  tx_q;

    ////////////////////////////////////////////////////////////
    // Byte FIFO
    ////////////////////////////////////////////////////////////
    assign full    = (count == UART_CNT_W'(UART_FIFO_DEPTH));
    assign do_push = push_i && !full;  // Dropped when full
    assign do_pop  = (state == TX_IDLE) && (count != '0);

    always_ff @(posedge clk) begin
        if (do_push) begin
            fifo[wr_ptr] <= byte_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Serializer
    ////////////////////////////////////////////////////////////
    assign bit_end = (bit_tmr == UART_TMR_W'(UART_CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= TX_IDLE;
            bit_tmr <= '0;
            bit_idx <= 3'd0;
            tx_q    <= 1'b1;
        end else begin
            bit_tmr <= bit_end ? '0 : bit_tmr + 1'b1;
            case (state)
                TX_IDLE: begin
                    bit_tmr <= '0;
                    if (do_pop) begin
                        shift_q <= fifo[rd_ptr];
                        tx_q    <= 1'b0; // Start bit
                        state   <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        tx_q    <= shift_q[0];
                        shift_q <= shift_q >> 1;
                        bit_idx <= 3'd0;
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            tx_q  <= 1'b1; // Stop bit
                            state <= TX_STOP;
                        end else begin
                            tx_q    <= shift_q[0];
                            shift_q <= shift_q >> 1;
                            bit_idx <= bit_idx + 3'd1;
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) state <= TX_IDLE;
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    assign not_full_o = !full;
    assign idle_o     = (count == '0) && (state == TX_IDLE);
    assign tx_o       = tx_q;

endmodule

// ==== mem_subsystem.sv ====
`timescale 1ns/1ns

module mem_subsystem (
    input  logic                clk,
    input  logic                rst,
    input  mem_pkg::hazard_t    hazard_i,
    // Fetch side
    input  logic [31:0]         pc_i,
    output logic [31:0]         inst_o,
    output logic [31:0]         id_pc_o,
    // Load/store side
    input  logic [31:0]         data_addr_i,
    input  logic                data_we_i,
    input  mem_pkg::mem_width_t width_i,
    input  logic [31:0]         wdata_i,
    output logic [31:0]         rdata_o,
    // Interrupt lines and serial out
    output logic                msip_o,
    output logic                mtip_o,
    output logic                uart_tx_o
);
    import mem_pkg::*;

    logic [31:0] fetch_word;
    logic [31:0] ram_off;
    logic [31:0] ram_rdata;
    logic [31:0] clint_rdata;
    logic        ram_hit;
    logic        clint_hit;
    logic        uart_tx_hit;
    logic        uart_stat_hit;
    logic        wr_ok;
    logic        uart_not_full;
    logic        uart_idle;

    ////////////////////////////////////////////////////////////
    // Region decode
    ////////////////////////////////////////////////////////////
    assign ram_off   = data_addr_i - RAM_BASE;
    assign ram_hit   = (data_addr_i >= RAM_BASE) && (data_addr_i < RAM_BASE + RAM_BYTES);
    assign clint_hit = (data_addr_i >= CLINT_MSIP_ADDR) && (data_addr_i <= CLINT_MTIMEH_ADDR);
    assign uart_tx_hit   = (data_addr_i == UART_TX_ADDR);
    assign uart_stat_hit = (data_addr_i == UART_STATUS_ADDR);

    assign wr_ok = data_we_i && (hazard_i != HZ_STALL_MMU); // MMU stall blocks stores

    // Unmapped reads return zero
    always_comb begin
        if (ram_hit)            rdata_o = ram_rdata;
        else if (clint_hit)     rdata_o = clint_rdata;
        else if (uart_stat_hit) rdata_o = {30'h0, uart_idle, uart_not_full};
        else                    rdata_o = 32'h0;
    end

    ////////////////////////////////////////////////////////////
    // Instances
    ////////////////////////////////////////////////////////////
    unified_ram unified_ram_i (
        .clk          (clk),
        .fetch_addr_i (pc_i),
        .fetch_word_o (fetch_word),
        .we_i         (wr_ok && ram_hit),
        .word_idx_i   (ram_off[MEM_IDX_W+1:2]),
        .offset_i     (ram_off[1:0]),
        .width_i      (width_i),
        .wdata_i      (wdata_i),
        .rdata_o      (ram_rdata)
    );

    fetch_stage fetch_stage_i (
        .clk          (clk),
        .rst          (rst),
        .hazard_i     (hazard_i),
        .pc_i         (pc_i),
        .fetch_word_i (fetch_word),
        .inst_o       (inst_o),
        .id_pc_o      (id_pc_o)
    );

    clint_timer clint_timer_i (
        .clk     (clk),
        .rst     (rst),
        .we_i    (wr_ok && clint_hit),
        .addr_i  (data_addr_i),
        .wdata_i (wdata_i),
        .rdata_o (clint_rdata),
        .msip_o  (msip_o),
        .mtip_o  (mtip_o)
    );

    uart_tx uart_tx_i (
        .clk        (clk),
        .rst        (rst),
        .push_i     (wr_ok && uart_tx_hit), // One strobe per store cycle
        .byte_i     (wdata_i[7:0]),
        .not_full_o (uart_not_full),
        .idle_o     (uart_idle),
        .tx_o       (uart_tx_o)
    );

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
    output logic clk_o,
    output logic rst_o
);
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o; // 20 ns period
    end

    // Reset held for four rising edges
    initial begin
        rst_o = 1'b1;
        repeat (4) @(posedge clk_o);
        #2 rst_o = 1'b0;
    end

endmodule

// ==== mem_subsystem_checker.sv ====
`timescale 1ns/1ns

module mem_subsystem_checker (
    input logic        clk,
    input logic        rst,
    input logic [31:0] inst_o,
    input logic        mtip_o,
    input logic        uart_tx_o
);
    import mem_pkg::*;

    logic [4:0] since_rst; // Saturating cycle count after reset

    always_ff @(posedge clk) begin
        if (rst) begin
            since_rst <= 5'd0;
        end else if (since_rst != 5'd31) begin
            since_rst <= since_rst + 5'd1;
        end
    end

    // Serial line rests high in reset
    assert property (@(posedge clk) rst && $past(rst) |-> uart_tx_o)
        else $error("uart_tx_o low while rst is high");

    assert property (@(posedge clk) $fell(rst) |-> inst_o == INST_NOP)
        else $error("inst_o is not a NOP after reset");

    // mtimecmp starts at all ones
    assert property (@(posedge clk) !rst && since_rst < 5'd16 |-> !mtip_o)
        else $error("mtip_o high shortly after reset");

endmodule

// ==== mem_subsystem_tb.sv ====
`timescale 1ns/1ns

module mem_subsystem_tb;
    import mem_pkg::*;

    logic        clk;
    logic        rst;
    hazard_t     hazard;
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] id_pc;
    logic [31:0] data_addr;
    logic        data_we;
    mem_width_t  width;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        msip;
    logic        mtip;
    logic        uart_tx;

    logic [31:0] ref_mem [0:MEM_WORDS-1]; // Reference RAM image
    mem_width_t  all_widths [5] = '{MW_B, MW_H, MW_W, MW_BU, MW_HU};

    tb_clock tb_clock_i (.clk_o(clk), .rst_o(rst));

    mem_subsystem mem_subsystem_i (
        .clk         (clk),
        .rst         (rst),
        .hazard_i    (hazard),
        .pc_i        (pc),
        .inst_o      (inst),
        .id_pc_o     (id_pc),
        .data_addr_i (data_addr),
        .data_we_i   (data_we),
        .width_i     (width),
        .wdata_i     (wdata),
        .rdata_o     (rdata),
        .msip_o      (msip),
        .mtip_o      (mtip),
        .uart_tx_o   (uart_tx)
    );

    bind mem_subsystem mem_subsystem_checker mem_subsystem_checker_i (.*);

    ////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks
    ////////////////////////////////////////////////////////////
    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic fail_with(input string why);
        $display("%0t: %s", $time, why);
        abort_run();
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %08h actual %08h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %02h actual %02h", $time, name, exp, act);
            abort_run();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model and bus drivers
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] expect_load(input logic [31:0] word, input logic [1:0] off,
                                                input mem_width_t w);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> (8 * off));
        h = 16'(word >> (8 * off));
        case (w)
            MW_B:    return {{24{b[7]}}, b};
            MW_BU:   return {24'h0, b};
            MW_H:    return off[0] ? 32'h0 : {{16{h[15]}}, h};
            MW_HU:   return off[0] ? 32'h0 : {16'h0, h};
            MW_W:    return (off == 2'd0) ? word : 32'h0;
            default: return 32'h0;
        endcase
    endfunction

    task automatic model_store(input logic [31:0] addr, input mem_width_t w, input logic [31:0] d);
        int         idx;
        logic [1:0] off;
        idx = int'((addr - RAM_BASE) >> 2);
        off = addr[1:0];
        case (w)
            MW_B: ref_mem[idx][8*off +: 8] = d[7:0];
            MW_H: if (!off[0]) ref_mem[idx][8*off +: 16] = d[15:0];
            MW_W: if (off == 2'd0) ref_mem[idx] = d;
            default: ;
        endcase
    endtask

    task automatic store_data(input logic [31:0] addr, input mem_width_t w, input logic [31:0] d);
        @(posedge clk);
        #2;
        data_addr = addr;
        width     = w;
        wdata     = d;
        data_we   = 1'b1;
        @(posedge clk);
        #2 data_we = 1'b0;
    endtask

    task automatic write_ram(input logic [31:0] addr, input mem_width_t w, input logic [31:0] d);
        store_data(addr, w, d);
        model_store(addr, w, d);
    endtask

    task automatic read_data(input logic [31:0] addr, input mem_width_t w,
                             output logic [31:0] val);
        @(posedge clk);
        #2;
        data_addr = addr;
        width     = w;
        data_we   = 1'b0;
        #5 val = rdata;
    endtask

    task automatic fetch_step(input hazard_t hz, input logic [31:0] pc_val);
        @(posedge clk);
        #2;
        hazard = hz;
        pc     = pc_val;
        @(posedge clk);
        #1;
    endtask

    // Samples each bit in its middle
    task automatic decode_byte(output logic [7:0] b);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #1 n++;
        end while (uart_tx && n < 2000);
        if (uart_tx) fail_with("no start bit seen on uart_tx_o");
        repeat (UART_CLKS_PER_BIT / 2) @(posedge clk);
        #1 if (uart_tx) fail_with("start bit on uart_tx_o ended early");
        for (int k = 0; k < 8; k++) begin
            repeat (UART_CLKS_PER_BIT) @(posedge clk);
            #1 b[k] = uart_tx;
        end
        repeat (UART_CLKS_PER_BIT) @(posedge clk);
        #1 if (!uart_tx) fail_with("stop bit on uart_tx_o is low");
    endtask

    task automatic wait_uart_idle(input int limit);
        logic [31:0] status;
        status = 32'h0;
        for (int n = 0; n < limit && !status[1]; n++) begin
            read_data(UART_STATUS_ADDR, MW_W, status);
        end
        if (!status[1]) fail_with("UART status never showed an idle line");
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////
    task automatic ram_lane_access();
        int          idx;
        logic [31:0] base;
        logic [31:0] got;
        logic [1:0]  off;
        for (int t = 0; t < 6; t++) begin
            idx  = int'($urandom % MEM_WORDS);
            base = RAM_BASE + 32'(idx * 4);
            write_ram(base, MW_W, $urandom);
            off = 2'($urandom) & 2'b10;
            write_ram(base + 32'(off), MW_H, $urandom);
            off = 2'($urandom);
            write_ram(base + 32'(off), MW_B, $urandom);
            write_ram(base + 32'd1, MW_H, $urandom); // Misaligned and dropped
            write_ram(base + 32'd2, MW_W, $urandom);
            for (int o = 0; o < 4; o++) begin
                for (int k = 0; k < 5; k++) begin
                    read_data(base + 32'(o), all_widths[k], got);
                    check_word("rdata_o", expect_load(ref_mem[idx], 2'(o), all_widths[k]), got);
                end
            end
        end
    endtask

    task automatic fetch_with_hazards();
        logic [31:0] pc_a;
        for (int i = 0; i < 8; i++) write_ram(RAM_BASE + 32'((32 + i) * 4), MW_W, $urandom);
        for (int i = 0; i < 8; i++) begin
            pc_a = RAM_BASE + 32'((32 + i) * 4);
            fetch_step(HZ_NONE, pc_a);
            check_word("inst_o", ref_mem[32 + i], inst);
            check_word("id_pc_o", pc_a, id_pc);
        end
        fetch_step(HZ_FLUSH_EARLY, pc_a - 32'd4);
        check_word("inst_o", INST_NOP, inst);
        fetch_step(HZ_NONE, pc_a - 32'd4);
        check_word("inst_o", ref_mem[38], inst);
        fetch_step(HZ_STALL_EARLY, pc_a);
        check_word("inst_o", ref_mem[38], inst);
        check_word("id_pc_o", pc_a - 32'd4, id_pc);
        fetch_step(HZ_STALL_MMU, RAM_BASE + 32'd128);
        check_word("inst_o", ref_mem[38], inst);
        check_word("id_pc_o", pc_a - 32'd4, id_pc);
        fetch_step(HZ_FLUSH_ALL, pc_a);
        check_word("inst_o", INST_NOP, inst);
        @(posedge clk);
        #2 hazard = HZ_NONE;
    endtask

    task automatic blocked_store_and_unmapped();
        logic [31:0] addr;
        logic [31:0] got;
        addr = RAM_BASE + 32'(($urandom % MEM_WORDS) * 4);
        write_ram(addr, MW_W, $urandom);
        @(posedge clk);
        #2 hazard = HZ_STALL_MMU;
        store_data(addr, MW_W, ~ref_mem[(addr - RAM_BASE) >> 2]); // Must not land
        hazard = HZ_NONE;
        read_data(addr, MW_W, got);
        check_word("rdata_o", ref_mem[(addr - RAM_BASE) >> 2], got);
        read_data(32'h4000_0000, MW_W, got);
        check_word("rdata_o", 32'h0, got);
        read_data(RAM_BASE + 32'(MEM_WORDS * 4), MW_W, got);
        check_word("rdata_o", 32'h0, got);
    endtask

    task automatic clint_regs();
        logic [31:0] t0;
        logic [31:0] t1;
        logic [31:0] hi;
        logic [31:0] got;
        check_bit("mtip_o", 1'b0, mtip);
        store_data(CLINT_MSIP_ADDR, MW_W, 32'h1);
        read_data(CLINT_MSIP_ADDR, MW_W, got);
        check_word("rdata_o", 32'h1, got);
        check_bit("msip_o", 1'b1, msip);
        store_data(CLINT_MSIP_ADDR, MW_W, 32'h0);
        read_data(CLINT_MSIP_ADDR, MW_W, got);
        check_word("rdata_o", 32'h0, got);
        check_bit("msip_o", 1'b0, msip);

        read_data(CLINT_MTIMEH_ADDR, MW_W, hi);
        read_data(CLINT_MTIME_ADDR, MW_W, t0);
        store_data(CLINT_MTIMECMP_ADDR, MW_W, t0 + 32'd20);
        store_data(CLINT_MTIMECMPH_ADDR, MW_W, hi);
        check_bit("mtip_o", 1'b0, mtip);
        for (int n = 0; n < 100 && !mtip; n++) begin
            @(posedge clk);
            #1;
        end
        if (!mtip) fail_with("mtip_o did not rise within 100 cycles");

        read_data(CLINT_MTIME_ADDR, MW_W, t0);
        read_data(CLINT_MTIME_ADDR, MW_W, t1);
        check_bit("mtime increasing", 1'b1, t1 > t0);
    endtask

    task automatic uart_frames();
        logic [7:0]  sent [3];
        logic [7:0]  got [3];
        logic [31:0] status;
        for (int i = 0; i < 3; i++) sent[i] = 8'($urandom);
        fork
            begin
                for (int i = 0; i < 3; i++) store_data(UART_TX_ADDR, MW_W, {24'h0, sent[i]});
            end
            begin
                for (int j = 0; j < 3; j++) decode_byte(got[j]);
            end
        join
        for (int i = 0; i < 3; i++) check_byte("uart_tx_o byte", sent[i], got[i]);
        wait_uart_idle(300);

        // Overfill while the line is busy
        for (int i = 0; i < UART_FIFO_DEPTH + 2; i++) store_data(UART_TX_ADDR, MW_W, $urandom);
        read_data(UART_STATUS_ADDR, MW_W, status);
        check_bit("rdata_o[0]", 1'b0, status[0]);
        wait_uart_idle(2000);
        read_data(UART_STATUS_ADDR, MW_W, status);
        check_bit("rdata_o[0]", 1'b1, status[0]);
    endtask

    initial begin
        void'($urandom(32'h58174497));
        hazard    = HZ_NONE;
        pc        = RAM_BASE;
        data_addr = 32'h0;
        data_we   = 1'b0;
        width     = MW_W;
        wdata     = 32'h0;
        for (int n = 0; n < 20 && rst !== 1'b0; n++) @(posedge clk);
        if (rst !== 1'b0) fail_with("reset was never released");

        ram_lane_access();
        fetch_with_hazards();
        blocked_store_and_unmapped();
        clint_regs();
        uart_frames();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== tb.f ====
mem_pkg.sv
unified_ram.sv
fetch_stage.sv
clint_timer.sv
uart_tx.sv
mem_subsystem.sv
tb_clock.sv
mem_subsystem_checker.sv
mem_subsystem_tb.sv

// ==== Makefile ====
SRCS = mem_pkg.sv unified_ram.sv fetch_stage.sv clint_timer.sv uart_tx.sv \
       mem_subsystem.sv tb_clock.sv mem_subsystem_checker.sv mem_subsystem_tb.sv

.PHONY: run clean

obj_dir/Vmem_subsystem_tb: tb.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module mem_subsystem_tb \
		-f tb.f -o Vmem_subsystem_tb

run: obj_dir/Vmem_subsystem_tb
	-./obj_dir/Vmem_subsystem_tb > sim.log 2>&1
	cat sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
